/* flist.f */
hdl/blit_fifo_pkg.sv
hdl/blit_enq_stage.sv
hdl/blit_pixel_lane.sv
hdl/blit_fifo_ctrl.sv
hdl/blit_fifo_top.sv
tb/blit_fifo_tb.sv

/* hdl/blit_enq_stage.sv */
// Enqueue stage: registers a request and expands its count into a pixel write mask
module blit_enq_stage (
    input  logic                       CLK,
    input  logic                       RESET_n,
    input  logic                       clear,
    input  logic                       enq_fire,
    input  blit_fifo_pkg::enq_req_t    enq_req,
    output blit_fifo_pkg::pix_write_t  pix_write
);

    logic [blit_fifo_pkg::MAX_PIXELS_PER_WORD-1:0] mask_next;
    logic [blit_fifo_pkg::MAX_PIXELS_PER_WORD-1:0] wr_mask;
    logic [blit_fifo_pkg::COUNT_BITS-1:0]          wr_count;
    logic [blit_fifo_pkg::WORD_BITS-1:0]           wr_data;

    // Thermometer code, the first count pixels are written
    always_comb begin
        for (int i = 0; i < blit_fifo_pkg::MAX_PIXELS_PER_WORD; i++) begin
            mask_next[i] = (enq_req.count > i);
        end
    end

    // Mask drops to zero when idle, so a stale request never writes twice
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_mask <= '0;
        end else if (clear || !enq_fire) begin
            wr_mask <= '0;
        end else begin
            wr_mask <= mask_next;
        end
    end

    // Count and data latched together with the mask
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            wr_count <= enq_req.count;
            wr_data  <= enq_req.data;
        end
    end

    assign pix_write = '{mask: wr_mask, count: wr_count, data: wr_data};

endmodule

/* hdl/blit_fifo_ctrl.sv */
// Blitter FIFO control: strobe qualification, dot counter, free count, output lane select
module blit_fifo_ctrl (
    input  logic                                  CLK,
    input  logic                                  RESET_n,
    input  logic                                  clk_en,
    input  logic                                  clear,
    input  blit_fifo_pkg::color_mode_e            color_mode,
    input  logic                                  enq,
    input  logic [blit_fifo_pkg::COUNT_BITS-1:0]  enq_count,
    input  logic                                  deq,
    input  logic [blit_fifo_pkg::COUNT_BITS-1:0]  deq_count,
    input  logic [blit_fifo_pkg::WORD_BITS-1:0]   lane_word_2,
    input  logic [blit_fifo_pkg::WORD_BITS-1:0]   lane_word_4,
    input  logic [blit_fifo_pkg::WORD_BITS-1:0]   lane_word_8,
    input  logic [blit_fifo_pkg::WORD_BITS-1:0]   lane_word_16,
    output logic                                  enq_fire,
    output logic                                  deq_fire,
    output logic [blit_fifo_pkg::WORD_BITS-1:0]   deq_data,
    output logic [blit_fifo_pkg::FILL_BITS-1:0]   avail_count,
    output logic [blit_fifo_pkg::FILL_BITS-1:0]   free_count
);

    logic [blit_fifo_pkg::FILL_BITS-1:0] enq_dots;
    logic [blit_fifo_pkg::FILL_BITS-1:0] deq_dots;

    // Strobes only count on enabled cycles
    assign enq_fire = enq & clk_en;
    assign deq_fire = deq & clk_en;

    // Dots added and removed this cycle, zero when the strobe is idle
    always_comb begin
        enq_dots = '0;
        deq_dots = '0;
        if (enq_fire) begin
            enq_dots = {{(blit_fifo_pkg::FILL_BITS - blit_fifo_pkg::COUNT_BITS){1'b0}},
                        enq_count};
        end
        if (deq_fire) begin
            deq_dots = {{(blit_fifo_pkg::FILL_BITS - blit_fifo_pkg::COUNT_BITS){1'b0}},
                        deq_count};
        end
    end

    // Fill counter, enqueue and dequeue may land in the same cycle
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            avail_count <= '0;
        end else if (clear) begin
            avail_count <= '0;
        end else begin
            avail_count <= avail_count + enq_dots - deq_dots;
        end
    end

    assign free_count = blit_fifo_pkg::LANE_CAPACITY[color_mode] - avail_count;

    // Output word comes from the lane of the current depth
    always_comb begin
        case (color_mode)
            blit_fifo_pkg::CM_2BPP:  deq_data = lane_word_2;
            blit_fifo_pkg::CM_4BPP:  deq_data = lane_word_4;
            blit_fifo_pkg::CM_8BPP:  deq_data = lane_word_8;
            default:                 deq_data = lane_word_16;
        endcase
    end

    // Caller must stay inside the free space and one word of pixels
    enq_within_limits: assert property (
        @(posedge CLK) disable iff (!RESET_n || clear)
        enq_fire |-> (enq_count <= free_count) &&
                     (enq_count <= blit_fifo_pkg::PIXELS_PER_WORD[color_mode])
    ) else $error("enqueue of %0d dots exceeds limits, free %0d", enq_count, free_count);

    // No dequeue past what has been enqueued
    deq_within_avail: assert property (
        @(posedge CLK) disable iff (!RESET_n || clear)
        deq_fire |-> (deq_count <= avail_count)
    ) else $error("dequeue of %0d dots exceeds avail %0d", deq_count, avail_count);

endmodule

/* hdl/blit_fifo_pkg.sv */
// Blitter pixel FIFO package: widths, colour modes, request structs, per-mode capacities
package blit_fifo_pkg;

    // Data word on both sides of the FIFO
    localparam int WORD_BITS = 32;

    // Storage held by each lane
    localparam int LANE_BITS = 64;

    // Pixels in one word at 2bpp, also the write mask width
    localparam int MAX_PIXELS_PER_WORD = 16;

    // Enqueue and dequeue counts, 0 to 16
    localparam int COUNT_BITS = 5;

    // Fill and free counts, 0 to 32
    localparam int FILL_BITS = 6;

    typedef enum logic [1:0] {
        CM_2BPP  = 2'd0,
        CM_4BPP  = 2'd1,
        CM_8BPP  = 2'd2,
        CM_16BPP = 2'd3
    } color_mode_e;

    // Pixels one lane can hold, by colour mode
    localparam logic [FILL_BITS-1:0] LANE_CAPACITY [4] = '{
        6'd32,
        6'd16,
        6'd8,
        6'd4
    };

    // Pixels carried by one word, by colour mode
    localparam logic [COUNT_BITS-1:0] PIXELS_PER_WORD [4] = '{
        5'd16,
        5'd8,
        5'd4,
        5'd2
    };

    // Enqueue request as seen on the top-level port
    typedef struct packed {
        logic [COUNT_BITS-1:0] count;
        logic [WORD_BITS-1:0]  data;
    } enq_req_t;

    // Registered write shared by all lanes
    // mask bit i enables pixel i counted from the MSB
    typedef struct packed {
        logic [MAX_PIXELS_PER_WORD-1:0] mask;
        logic [COUNT_BITS-1:0]          count;
        logic [WORD_BITS-1:0]           data;
    } pix_write_t;

endpackage

/* hdl/blit_fifo_top.sv */
// Blitter pixel FIFO top level: control, enqueue stage and four pixel lanes
module blit_fifo_top (
    input  logic                                  CLK,
    input  logic                                  RESET_n,
    input  logic                                  clk_en,
    input  logic                                  clear,
    input  blit_fifo_pkg::color_mode_e            color_mode,
    input  logic                                  enq,
    input  blit_fifo_pkg::enq_req_t               enq_req,
    input  logic                                  deq,
    input  logic [blit_fifo_pkg::COUNT_BITS-1:0]  deq_count,
    output logic [blit_fifo_pkg::WORD_BITS-1:0]   deq_data,
    output logic [blit_fifo_pkg::FILL_BITS-1:0]   avail_count,
    output logic [blit_fifo_pkg::FILL_BITS-1:0]   free_count
);

    logic                                 enq_fire;
    logic                                 deq_fire;
    blit_fifo_pkg::pix_write_t            pix_write;
    logic [blit_fifo_pkg::WORD_BITS-1:0]  lane_word_2;
    logic [blit_fifo_pkg::WORD_BITS-1:0]  lane_word_4;
    logic [blit_fifo_pkg::WORD_BITS-1:0]  lane_word_8;
    logic [blit_fifo_pkg::WORD_BITS-1:0]  lane_word_16;

    blit_fifo_ctrl blit_fifo_ctrl_i (
        .CLK          (CLK),
        .RESET_n      (RESET_n),
        .clk_en       (clk_en),
        .clear        (clear),
        .color_mode   (color_mode),
        .enq          (enq),
        .enq_count    (enq_req.count),
        .deq          (deq),
        .deq_count    (deq_count),
        .lane_word_2  (lane_word_2),
        .lane_word_4  (lane_word_4),
        .lane_word_8  (lane_word_8),
        .lane_word_16 (lane_word_16),
        .enq_fire     (enq_fire),
        .deq_fire     (deq_fire),
        .deq_data     (deq_data),
        .avail_count  (avail_count),
        .free_count   (free_count)
    );

    blit_enq_stage blit_enq_stage_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .clear     (clear),
        .enq_fire  (enq_fire),
        .enq_req   (enq_req),
        .pix_write (pix_write)
    );

    // Every depth is filled in parallel, the mode only picks the output
    blit_pixel_lane #(.PIX_BITS(2)) blit_pixel_lane_2_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .clear     (clear),
        .pix_write (pix_write),
        .deq_fire  (deq_fire),
        .deq_count (deq_count),
        .lane_word (lane_word_2)
    );

    blit_pixel_lane #(.PIX_BITS(4)) blit_pixel_lane_4_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .clear     (clear),
        .pix_write (pix_write),
        .deq_fire  (deq_fire),
        .deq_count (deq_count),
        .lane_word (lane_word_4)
    );

    blit_pixel_lane #(.PIX_BITS(8)) blit_pixel_lane_8_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .clear     (clear),
        .pix_write (pix_write),
        .deq_fire  (deq_fire),
        .deq_count (deq_count),
        .lane_word (lane_word_8)
    );

    blit_pixel_lane #(.PIX_BITS(16)) blit_pixel_lane_16_i (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .clear     (clear),
        .pix_write (pix_write),
        .deq_fire  (deq_fire),
        .deq_count (deq_count),
        .lane_word (lane_word_16)
    );

endmodule

/* hdl/blit_pixel_lane.sv */
// Pixel lane: circular buffer of one pixel depth with write and read offsets per word slot
module blit_pixel_lane #(
    parameter int PIX_BITS = 8
) (
    input  logic                                  CLK,
    input  logic                                  RESET_n,
    input  logic                                  clear,
    input  blit_fifo_pkg::pix_write_t             pix_write,
    input  logic                                  deq_fire,
    input  logic [blit_fifo_pkg::COUNT_BITS-1:0]  deq_count,
    output logic [blit_fifo_pkg::WORD_BITS-1:0]   lane_word
);

    localparam int PPW      = blit_fifo_pkg::WORD_BITS / PIX_BITS;
    localparam int DEPTH    = blit_fifo_pkg::LANE_BITS / PIX_BITS;
    localparam int OFS_BITS = $clog2(DEPTH);

    logic [PIX_BITS-1:0]                 pixel_mem [DEPTH];
    logic [OFS_BITS-1:0]                 wr_ofs [PPW];
    logic [OFS_BITS-1:0]                 rd_ofs [PPW];
    logic [OFS_BITS-1:0]                 wr_step;
    logic [OFS_BITS-1:0]                 rd_step;
    logic                                wr_any;
    logic [blit_fifo_pkg::WORD_BITS-1:0] rd_word;

    // Depth is a power of two, so truncation wraps the offsets
    assign wr_step = OFS_BITS'(pix_write.count);
    assign rd_step = OFS_BITS'(deq_count);
    assign wr_any  = |pix_write.mask;

    // Write offsets, slot i starts at pixel i
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < PPW; i++) begin
                wr_ofs[i] <= OFS_BITS'(i);
            end
        end else if (clear) begin
            for (int i = 0; i < PPW; i++) begin
                wr_ofs[i] <= OFS_BITS'(i);
            end
        end else if (wr_any) begin
            for (int i = 0; i < PPW; i++) begin
                wr_ofs[i] <= wr_ofs[i] + wr_step;
            end
        end
    end

    // Pixel storage, pixel 0 of the word sits in the top bits
    // A write still pending at clear is dropped
    always_ff @(posedge CLK) begin
        for (int i = 0; i < PPW; i++) begin
            if (pix_write.mask[i] && !clear) begin
                pixel_mem[wr_ofs[i]] <=
                    pix_write.data[blit_fifo_pkg::WORD_BITS-1-i*PIX_BITS -: PIX_BITS];
            end
        end
    end

    // Gather one word starting at the read pointer
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < PPW; i++) begin
            rd_word[blit_fifo_pkg::WORD_BITS-1-i*PIX_BITS -: PIX_BITS] = pixel_mem[rd_ofs[i]];
        end
    end

    // Read offsets move by the consumed count only
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < PPW; i++) begin
                rd_ofs[i] <= OFS_BITS'(i);
            end
        end else if (clear) begin
            for (int i = 0; i < PPW; i++) begin
                rd_ofs[i] <= OFS_BITS'(i);
            end
        end else if (deq_fire) begin
            for (int i = 0; i < PPW; i++) begin
                rd_ofs[i] <= rd_ofs[i] + rd_step;
            end
        end
    end

    // Output word holds until the next dequeue
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            lane_word <= '0;
        end else if (deq_fire && !clear) begin
            lane_word <= rd_word;
        end
    end

    // Mask bits past this lane come from a wider word
    // in that case every slot of this lane is enabled as well
    wide_write_fills_lane: assert property (
        @(posedge CLK) disable iff (!RESET_n)
        ((pix_write.mask >> PPW) != '0) |-> (&pix_write.mask[PPW-1:0])
    ) else $error("write mask %h not contiguous in %0d bpp lane", pix_write.mask, PIX_BITS);

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the blitter pixel FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module blit_fifo_tb -f flist.f -o blit_fifo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/blit_fifo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

exit 0

/* tb/blit_fifo_tb.sv */
// Testbench for the blitter pixel FIFO: clock, reset, LFSR stimulus, pixel queue model, checks
module blit_fifo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int ROUND_OPS     = 150;
    localparam int FIXED_CYCLES  = 64;
    localparam int MARGIN_CYCLES = 100;
    localparam int TEST_CYCLES   = RESET_CYCLES + 4 * (ROUND_OPS + 1) + FIXED_CYCLES;
    localparam logic [31:0] SEED = 32'h3094_40ca;

    logic                                  CLK;
    logic                                  RESET_n;
    logic                                  clk_en;
    logic                                  clear;
    blit_fifo_pkg::color_mode_e            color_mode;
    logic                                  enq;
    blit_fifo_pkg::enq_req_t               enq_req;
    logic                                  deq;
    logic [blit_fifo_pkg::COUNT_BITS-1:0]  deq_count;
    logic [blit_fifo_pkg::WORD_BITS-1:0]   deq_data;
    logic [blit_fifo_pkg::FILL_BITS-1:0]   avail_count;
    logic [blit_fifo_pkg::FILL_BITS-1:0]   free_count;

    // Reference model state
    int unsigned pix_q [$];
    int unsigned exp_pix [16];
    int          exp_n;
    int          exp_avail;
    // Fill the DUT shows until the next edge
    int          avail_now;
    int          mode_bpp;
    int          mode_cap;
    int          mode_ppw;
    bit          last_enq;
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    blit_fifo_top blit_fifo_top_i (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .clk_en      (clk_en),
        .clear       (clear),
        .color_mode  (color_mode),
        .enq         (enq),
        .enq_req     (enq_req),
        .deq         (deq),
        .deq_count   (deq_count),
        .deq_data    (deq_data),
        .avail_count (avail_count),
        .free_count  (free_count)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Free space is capacity of the mode minus the model fill, on every edge
    free_tracks_avail: assert property (
        @(posedge CLK) disable iff (!RESET_n)
        free_count == 6'(mode_cap - avail_now)
    ) else begin
        $display("[FAIL] free_count expected %h actual %h",
                 6'($sampled(mode_cap) - $sampled(avail_now)), $sampled(free_count));
        errors++;
    end

    // Galois LFSR, right shift form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit, first bit ends up on top
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // Pixel j of a word, counted from the MSB
    function automatic int unsigned pixel_of(input logic [31:0] word, input int j, input int b);
        return int'((word >> (32 - (j + 1) * b)) & ((32'd1 << b) - 32'd1));
    endfunction

    task automatic check_outputs();
        int unsigned got;
        checks++;
        assert (avail_count == 6'(exp_avail)) else begin
            $display("[FAIL] avail_count expected %h actual %h", 6'(exp_avail), avail_count);
            errors++;
        end
        for (int j = 0; j < exp_n; j++) begin
            got = pixel_of(deq_data, j, mode_bpp);
            checks++;
            assert (got == exp_pix[j]) else begin
                $display("[FAIL] deq_data pixel %0d expected %h actual %h", j, exp_pix[j], got);
                errors++;
            end
        end
        avail_now = exp_avail;
    endtask

    // Drives one cycle from a falling edge and checks at the next one
    task automatic run_cycle(input bit do_enq, input int enq_cnt, input logic [31:0] enq_dat,
                             input bit do_deq, input int deq_cnt, input bit en);
        clk_en        = en;
        enq           = do_enq;
        enq_req.count = 5'(enq_cnt);
        enq_req.data  = enq_dat;
        deq           = do_deq;
        deq_count     = 5'(deq_cnt);
        // Dequeue sees the queue as it was before this cycle's enqueue
        if (en && do_deq) begin
            exp_n = min_int(pix_q.size(), mode_ppw);
            for (int j = 0; j < exp_n; j++) begin
                exp_pix[j] = pix_q[j];
            end
            repeat (deq_cnt) void'(pix_q.pop_front());
        end
        if (en && do_enq) begin
            for (int j = 0; j < enq_cnt; j++) begin
                pix_q.push_back(pixel_of(enq_dat, j, mode_bpp));
            end
        end
        exp_avail = pix_q.size();
        last_enq  = en && do_enq;
        @(posedge CLK);
        @(negedge CLK);
        check_outputs();
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 0, 32'h0, 1'b0, 0, 1'b1);
    endtask

    // Clear together with the new colour mode
    task automatic start_mode(input int m);
        clk_en     = 1'b1;
        clear      = 1'b1;
        color_mode = blit_fifo_pkg::color_mode_e'(m);
        enq        = 1'b0;
        enq_req    = '0;
        deq        = 1'b0;
        deq_count  = '0;
        mode_bpp   = 2 << m;
        mode_cap   = 64 / mode_bpp;
        mode_ppw   = 32 / mode_bpp;
        pix_q.delete();
        exp_avail  = 0;
        exp_n      = 0;
        last_enq   = 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        clear = 1'b0;
        check_outputs();
    endtask

    // Random enqueue, dequeue or both, inside the free and avail limits
    task automatic random_op();
        int          enq_lim;
        int          deq_lim;
        int          enq_cnt;
        int          deq_cnt;
        logic [1:0]  pick;
        bit          do_enq;
        bit          do_deq;
        logic [31:0] data;
        enq_lim = min_int(mode_cap - pix_q.size(), mode_ppw);
        deq_lim = min_int(pix_q.size(), mode_ppw);
        pick    = 2'(rand_bits(2));
        do_enq  = pick[0] && (enq_lim > 0);
        do_deq  = pick[1] && !last_enq;
        enq_cnt = do_enq ? 1 + int'(rand_bits(5)) % enq_lim : 0;
        deq_cnt = do_deq ? int'(rand_bits(5)) % (deq_lim + 1) : 0;
        data    = rand_bits(32);
        run_cycle(do_enq, enq_cnt, data, do_deq, deq_cnt, 1'b1);
    endtask

    task automatic report_test(input string name, input int err_start, input int chk_start);
        $display("test %-16s checks %0d errors %0d", name, checks - chk_start, errors - err_start);
    endtask

    initial begin
        int err_start;
        int chk_start;
        int enq_cnt;
        int deq_cnt;
        RESET_n    = 1'b0;
        clk_en     = 1'b1;
        clear      = 1'b0;
        color_mode = blit_fifo_pkg::CM_8BPP;
        enq        = 1'b0;
        enq_req    = '0;
        deq        = 1'b0;
        deq_count  = '0;
        lfsr_state = SEED;
        errors     = 0;
        checks     = 0;
        mode_bpp   = 8;
        mode_cap   = 8;
        mode_ppw   = 4;
        exp_avail  = 0;
        avail_now  = 0;
        last_enq   = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET_n = 1'b1;

        // Output word of all zero pixels after reset
        err_start = errors;
        chk_start = checks;
        exp_n     = mode_ppw;
        for (int j = 0; j < 16; j++) begin
            exp_pix[j] = 0;
        end
        check_outputs();
        checks++;
        assert (free_count == 6'(mode_cap)) else begin
            $display("[FAIL] free_count expected %h actual %h", 6'(mode_cap), free_count);
            errors++;
        end
        report_test("reset", err_start, chk_start);

        for (int m = 0; m < 4; m++) begin
            err_start = errors;
            chk_start = checks;
            start_mode(m);
            repeat (ROUND_OPS) random_op();
            report_test($sformatf("round_trip_%0dbpp", 2 << m), err_start, chk_start);
        end

        // Short dequeues at 4bpp consume only part of a word
        err_start = errors;
        chk_start = checks;
        start_mode(1);
        run_cycle(1'b1, 8, rand_bits(32), 1'b0, 0, 1'b1);
        run_cycle(1'b1, 8, rand_bits(32), 1'b0, 0, 1'b1);
        idle_cycle();
        run_cycle(1'b0, 0, 32'h0, 1'b1, 3, 1'b1);
        run_cycle(1'b0, 0, 32'h0, 1'b1, 5, 1'b1);
        run_cycle(1'b0, 0, 32'h0, 1'b1, 1, 1'b1);
        run_cycle(1'b0, 0, 32'h0, 1'b1, 7, 1'b1);
        report_test("partial_dequeue", err_start, chk_start);

        // Enqueue and dequeue in the same cycle at 2bpp
        err_start = errors;
        chk_start = checks;
        start_mode(0);
        run_cycle(1'b1, 10, rand_bits(32), 1'b0, 0, 1'b1);
        idle_cycle();
        repeat (8) begin
            enq_cnt = int'(rand_bits(5)) % (min_int(mode_cap - pix_q.size(), 16) + 1);
            deq_cnt = int'(rand_bits(5)) % (min_int(pix_q.size(), 16) + 1);
            run_cycle(1'b1, enq_cnt, rand_bits(32), 1'b1, deq_cnt, 1'b1);
            idle_cycle();
        end
        report_test("counters", err_start, chk_start);

        // Strobes with clk_en low, then a clear over a pending write
        err_start = errors;
        chk_start = checks;
        start_mode(2);
        run_cycle(1'b1, 4, rand_bits(32), 1'b0, 0, 1'b1);
        idle_cycle();
        run_cycle(1'b0, 0, 32'h0, 1'b1, 2, 1'b1);
        repeat (3) run_cycle(1'b1, 3, rand_bits(32), 1'b1, 1, 1'b0);
        run_cycle(1'b1, 2, rand_bits(32), 1'b0, 0, 1'b1);
        start_mode(2);
        run_cycle(1'b1, 4, rand_bits(32), 1'b0, 0, 1'b1);
        idle_cycle();
        run_cycle(1'b0, 0, 32'h0, 1'b1, 4, 1'b1);
        idle_cycle();
        report_test("clear_clk_en", err_start, chk_start);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Run time bound from the test lengths
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

endmodule
